// ==== disk_bridge_settings.svh ====
/*
 * Disk bridge settings
 * Bus and buffer widths, register map and the file numbers
 * reported for each drive slot
 */

`ifndef DISK_BRIDGE_SETTINGS_SVH
`define DISK_BRIDGE_SETTINGS_SVH

// Wishbone side
`define DISK_WB_ADR_W 2
`define DISK_WB_DAT_W 32

// Sector buffer and drive slots
`define DISK_BUF_AW 9
`define DISK_SLOTS 3

// Register map
`define DISK_REG_CTRL 2'd0
`define DISK_REG_STATUS 2'd1
`define DISK_REG_DATA 2'd2
`define DISK_REG_PTR_CLR 2'd3

// File number reported when a slot gets mounted
`define DISK_FILENO_SLOT0 3'd0
`define DISK_FILENO_SLOT1 3'd1
`define DISK_FILENO_SLOT2 3'd4

`endif

// ==== disk_bridge_pkg.sv ====
/*
 * Disk bridge types
 * Control and status words, the shared DATA word and the host-side bundles
 */

`include "disk_bridge_settings.svh"

package disk_bridge_pkg;

	// Control register, lba_sel sits in bit 0
	typedef struct packed {
		logic [2:0] drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} disk_ctrl_t;

	// Status register, io_done sits in bit 0
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} disk_status_t;

	typedef struct packed {
		logic [23:0] pad;
		logic [7:0]  data;
	} data_byte_t;

	// DATA register write value, LBA or buffer byte depending on lba_sel
	typedef union packed {
		logic [31:0] lba;
		data_byte_t  buf_byte;
	} data_word_u;

	typedef struct packed {
		logic [`DISK_SLOTS-1:0] rd;
		logic [`DISK_SLOTS-1:0] wr;
		logic [31:0]            lba;
	} sd_req_t;

	typedef struct packed {
		logic [`DISK_BUF_AW-1:0] addr;
		logic [7:0]              data;
		logic                    wr;
	} host_buf_t;

	typedef struct packed {
		logic [`DISK_SLOTS-1:0] mounted;
		logic                   readonly;
		logic [1:0]             file_type;
		logic [31:0]            size;
	} mount_info_t;

endpackage

// ==== disk_regs.sv ====
/*
 * Disk bridge register block
 * Wishbone classic slave with a fixed two-cycle ack, holds the control
 * register and turns each access into single-cycle strobes
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module disk_regs (
	input  logic                          clk_sys,
	input  logic                          areset,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [`DISK_WB_ADR_W-1:0]     wb_adr,
	input  logic [`DISK_WB_DAT_W-1:0]     wb_dat_w,
	output logic [`DISK_WB_DAT_W-1:0]     wb_dat_r,
	output logic                          wb_ack,
	input  disk_bridge_pkg::disk_status_t status,
	input  logic [31:0]                   file_size,
	input  logic [7:0]                    buf_q,
	output disk_bridge_pkg::disk_ctrl_t   ctrl,
	output disk_bridge_pkg::data_word_u   data_word,
	output logic                          lba_load,
	output logic                          buf_wr,
	output logic                          buf_adv,
	output logic                          ptr_clr
);

	logic                      bus_req;
	logic                      pending;
	logic                      access;
	logic                      wr_access;
	logic                      data_sel;
	logic [`DISK_WB_DAT_W-1:0] rd_mux;

	// ============================================================
	// Handshake
	// ============================================================

	assign bus_req = wb_cyc & wb_stb;

	// Cycle before ack, writes land at the edge where ack rises
	assign access    = bus_req & pending;
	assign wr_access = access & wb_we;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			pending <= 1'b0;
			wb_ack  <= 1'b0;
		end else begin
			pending <= bus_req & ~pending & ~wb_ack;
			wb_ack  <= access;
		end
	end

	// ============================================================
	// Control register and strobes
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ctrl <= '0;
		end else if (wr_access && wb_adr == `DISK_REG_CTRL) begin
			ctrl <= wb_dat_w[$bits(disk_bridge_pkg::disk_ctrl_t)-1:0];
		end
	end

	assign data_sel  = (wb_adr == `DISK_REG_DATA);
	assign data_word = wb_dat_w;

	assign lba_load = wr_access & data_sel & ctrl.lba_sel;
	assign buf_wr   = wr_access & data_sel & ~ctrl.lba_sel;
	assign ptr_clr  = wr_access & (wb_adr == `DISK_REG_PTR_CLR);

	// Read pointer moves once the byte has been handed out
	assign buf_adv = wb_ack & ~wb_we & data_sel & ~ctrl.lba_sel;

	// ============================================================
	// Read data
	// ============================================================

	always_comb begin
		case (wb_adr)
			`DISK_REG_CTRL:   rd_mux = `DISK_WB_DAT_W'(ctrl);
			`DISK_REG_STATUS: rd_mux = `DISK_WB_DAT_W'(status);
			`DISK_REG_DATA: begin
				if (ctrl.lba_sel) begin
					rd_mux = file_size;
				end else begin
					rd_mux = `DISK_WB_DAT_W'(buf_q);
				end
			end
			default:          rd_mux = '0;
		endcase
	end

	// Captured with ack so it stays valid for the whole ack cycle
	always_ff @(posedge clk_sys) begin
		if (access) begin
			wb_dat_r <= rd_mux;
		end
	end

endmodule

// ==== disk_request.sv ====
/*
 * Block request generator
 * Raises read and write requests per drive slot on control edges,
 * clears them on acknowledge and tracks io_done
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module disk_request (
	input  logic                        clk_sys,
	input  logic                        areset,
	input  disk_bridge_pkg::disk_ctrl_t ctrl,
	input  disk_bridge_pkg::data_word_u data_word,
	input  logic                        lba_load,
	input  logic [`DISK_SLOTS-1:0]      sd_ack,
	output disk_bridge_pkg::sd_req_t    sd_req,
	output logic                        io_done
);

	logic                   block_rd_q;
	logic                   block_wr_q;
	logic                   ack_any_q;
	logic                   ack_any;
	logic [1:0]             slot;
	logic [`DISK_SLOTS-1:0] slot_mask;
	logic [`DISK_SLOTS-1:0] req_rd;
	logic [`DISK_SLOTS-1:0] req_wr;
	logic [31:0]            lba_q;

	// Drive number bits 2 and 0 pick the slot, 3 maps to nothing
	assign slot      = {ctrl.drv_num[2], ctrl.drv_num[0]};
	assign slot_mask = (slot < 2'(`DISK_SLOTS)) ? `DISK_SLOTS'(1) << slot : '0;
	assign ack_any   = |sd_ack;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			block_rd_q <= 1'b0;
			block_wr_q <= 1'b0;
			ack_any_q  <= 1'b0;
			req_rd     <= '0;
			req_wr     <= '0;
			io_done    <= 1'b1;
		end else begin
			block_rd_q <= ctrl.block_rd;
			block_wr_q <= ctrl.block_wr;
			ack_any_q  <= ack_any;
			if (ctrl.block_rd && !block_rd_q) begin
				req_rd  <= req_rd | slot_mask;
				io_done <= 1'b0;
			end
			if (ctrl.block_wr && !block_wr_q) begin
				req_wr  <= req_wr | slot_mask;
				io_done <= 1'b0;
			end
			// Acknowledge wins over a new request edge
			if (ack_any) begin
				req_rd <= '0;
				req_wr <= '0;
			end
			if (ack_any_q && !ack_any) begin
				io_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (lba_load) begin
			lba_q <= data_word.lba;
		end
	end

	assign sd_req = '{rd: req_rd, wr: req_wr, lba: lba_q};

endmodule

// ==== sector_buffer.sv ====
/*
 * Sector buffer
 * 512 by 8 dual-port RAM, port A for the SD host and port B for the
 * bridge, addressed by an auto-incrementing pointer
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module sector_buffer (
	input  logic                        clk_sys,
	input  logic                        areset,
	input  logic                        buf_wr,
	input  logic                        buf_adv,
	input  logic                        ptr_clr,
	input  disk_bridge_pkg::data_word_u data_word,
	input  disk_bridge_pkg::host_buf_t  host_buf,
	output logic [7:0]                  buf_q,
	output logic [7:0]                  buff_din
);

	logic [7:0]              mem [2**`DISK_BUF_AW];
	logic [`DISK_BUF_AW-1:0] ptr;

	// Both ports share one process, the bridge write lands last on a clash
	always_ff @(posedge clk_sys) begin
		if (host_buf.wr) begin
			mem[host_buf.addr] <= host_buf.data;
		end
		if (buf_wr) begin
			mem[ptr] <= data_word.buf_byte.data;
		end
		buff_din <= mem[host_buf.addr];
		buf_q    <= mem[ptr];
	end

	// Clear beats advance
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr <= '0;
		end else if (ptr_clr) begin
			ptr <= '0;
		end else if (buf_wr || buf_adv) begin
			ptr <= ptr + 1'b1;
		end
	end

endmodule

// ==== mount_tracker.sv ====
/*
 * Mount tracker
 * Latches file number, type, read-only flag and size on each mount
 * event and toggles the mounted flag
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module mount_tracker (
	input  logic                         clk_sys,
	input  logic                         areset,
	input  disk_bridge_pkg::mount_info_t mount,
	output logic                         mounted_flag,
	output logic [2:0]                   fileno,
	output logic [1:0]                   filetype,
	output logic                         readonly,
	output logic [31:0]                  file_size
);

	logic [`DISK_SLOTS-1:0] mounted_q;
	logic                   mount_evt;
	logic [2:0]             slot_fileno;

	// A newly set bit in any slot counts as a mount event
	assign mount_evt = |(mount.mounted & ~mounted_q);

	// Highest mounted slot decides the file number
	always_comb begin
		if (mount.mounted[2]) begin
			slot_fileno = `DISK_FILENO_SLOT2;
		end else if (mount.mounted[1]) begin
			slot_fileno = `DISK_FILENO_SLOT1;
		end else begin
			slot_fileno = `DISK_FILENO_SLOT0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_q    <= '0;
			mounted_flag <= 1'b0;
		end else begin
			mounted_q <= mount.mounted;
			if (mount_evt) begin
				mounted_flag <= ~mounted_flag;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mount_evt) begin
			fileno    <= slot_fileno;
			filetype  <= mount.file_type;
			readonly  <= mount.readonly | mount.mounted[2];   // slot 2 is always read-only
			file_size <= mount.size;
		end
	end

endmodule

// ==== disk_bridge_top.sv ====
/*
 * Disk bridge top level
 * Connects the Wishbone register block to the block request logic,
 * the shared sector buffer and the mount tracker
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module disk_bridge_top (
	input  logic                          clk_sys,
	input  logic                          areset,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [`DISK_WB_ADR_W-1:0]     wb_adr,
	input  logic [`DISK_WB_DAT_W-1:0]     wb_dat_w,
	output logic [`DISK_WB_DAT_W-1:0]     wb_dat_r,
	output logic                          wb_ack,
	input  disk_bridge_pkg::host_buf_t    host_buf,
	output logic [7:0]                    buff_din,
	input  disk_bridge_pkg::mount_info_t  mount,
	input  logic [`DISK_SLOTS-1:0]        sd_ack,
	output disk_bridge_pkg::sd_req_t      sd_req
);

	disk_bridge_pkg::disk_ctrl_t   ctrl;
	disk_bridge_pkg::data_word_u   data_word;
	disk_bridge_pkg::disk_status_t status;
	logic                          lba_load;
	logic                          buf_wr;
	logic                          buf_adv;
	logic                          ptr_clr;
	logic [7:0]                    buf_q;
	logic [31:0]                   file_size;

	disk_regs i_regs (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.status    (status),
		.file_size (file_size),
		.buf_q     (buf_q),
		.ctrl      (ctrl),
		.data_word (data_word),
		.lba_load  (lba_load),
		.buf_wr    (buf_wr),
		.buf_adv   (buf_adv),
		.ptr_clr   (ptr_clr)
	);

	disk_request i_request (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.ctrl      (ctrl),
		.data_word (data_word),
		.lba_load  (lba_load),
		.sd_ack    (sd_ack),
		.sd_req    (sd_req),
		.io_done   (status.io_done)
	);

	sector_buffer i_buffer (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.buf_wr    (buf_wr),
		.buf_adv   (buf_adv),
		.ptr_clr   (ptr_clr),
		.data_word (data_word),
		.host_buf  (host_buf),
		.buf_q     (buf_q),
		.buff_din  (buff_din)
	);

	mount_tracker i_mount (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.mount        (mount),
		.mounted_flag (status.mounted),
		.fileno       (status.fileno),
		.filetype     (status.filetype),
		.readonly     (status.readonly),
		.file_size    (file_size)
	);

endmodule

// ==== disk_bridge_chk.sv ====
/*
 * Disk bridge checker
 * Bus and request handshake assertions on the bridge top level
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module disk_bridge_chk (
	input logic                     clk_sys,
	input logic                     areset,
	input logic                     wb_cyc,
	input logic                     wb_stb,
	input logic                     wb_ack,
	input logic [`DISK_SLOTS-1:0]   sd_ack,
	input disk_bridge_pkg::sd_req_t sd_req
);

	ack_in_cycle: assert property (@(posedge clk_sys) disable iff (areset)
		wb_ack |-> (wb_cyc && wb_stb))
	else $error("wb_ack high outside a bus cycle");

	// Only one request may be open at a time
	one_request: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0({sd_req.rd, sd_req.wr}))
	else $error("more than one block request open");

	req_cleared: assert property (@(posedge clk_sys) disable iff (areset)
		(|sd_ack) |=> (sd_req.rd == '0 && sd_req.wr == '0))
	else $error("block request still set after acknowledge");

endmodule

bind disk_bridge_top disk_bridge_chk i_chk (
	.clk_sys (clk_sys),
	.areset  (areset),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.sd_ack  (sd_ack),
	.sd_req  (sd_req)
);

// ==== tb_disk_bridge.sv ====
/*
 * Disk bridge testbench
 * Runs the operations of the tests file against the bridge through
 * Wishbone and the SD host side, and compares the responses
 */

`timescale 1ns/1ps
`include "disk_bridge_settings.svh"

module tb_disk_bridge;

	localparam int MAX_OPS     = 64;
	localparam int ACK_TIMEOUT = 16;

	logic                         clk_sys;
	logic                         areset;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	logic [`DISK_WB_ADR_W-1:0]    wb_adr;
	logic [`DISK_WB_DAT_W-1:0]    wb_dat_w;
	logic [`DISK_WB_DAT_W-1:0]    wb_dat_r;
	logic                         wb_ack;
	disk_bridge_pkg::host_buf_t   host_buf;
	logic [7:0]                   buff_din;
	disk_bridge_pkg::mount_info_t mount;
	logic [`DISK_SLOTS-1:0]       sd_ack;
	disk_bridge_pkg::sd_req_t     sd_req;

	// One line per operation: op, adr, value, expected
	logic [79:0] stim [MAX_OPS];
	// Bytes the host wrote into the buffer
	logic [7:0]  model [2**`DISK_BUF_AW];
	int          errors;
	int          checks;
	bit          timed_out;

	disk_bridge_top i_dut (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.host_buf (host_buf),
		.buff_din (buff_din),
		.mount    (mount),
		.sd_ack   (sd_ack),
		.sd_req   (sd_req)
	);

	always #50 clk_sys = ~clk_sys;

	// ============================================================
	// Helpers
	// ============================================================

	// Inputs change and outputs are sampled 5 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp_val);
		checks++;
		if (got !== exp_val) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp_val);
		end
	endtask

	// Classic cycle, stb held through the ack cycle and then dropped
	task automatic wb_access(input logic we, input logic [`DISK_WB_ADR_W-1:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		rdata    = '0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		cycles   = 0;
		next_cycle();
		while (wb_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (wb_ack !== 1'b1) begin
			$display("wishbone ack did not arrive within %0d cycles at %0t ns",
				ACK_TIMEOUT, $time);
			errors++;
			timed_out = 1'b1;
		end else begin
			rdata = wb_dat_r;
		end
		next_cycle();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		next_cycle();
	endtask

	// ============================================================
	// Operation sequence
	// ============================================================

	initial begin
		logic [79:0] line;
		logic [3:0]  op;
		logic [11:0] adr;
		logic [31:0] value;
		logic [31:0] exp_val;
		logic [31:0] rdata;
		logic [8:0]  maddr;
		logic [5:0]  n;
		bit          done;
		int          i;

		clk_sys   = 1'b0;
		areset    = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		host_buf  = '0;
		mount     = '0;
		sd_ack    = '0;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		void'($urandom(32'h7377fcdd));
		$readmemh("disk_bridge_tests.txt", stim);

		repeat (4) next_cycle();
		areset = 1'b0;

		n    = '0;
		done = 1'b0;
		while (!done) begin
			line    = stim[n];
			op      = line[79:76];
			adr     = line[75:64];
			value   = line[63:32];
			exp_val = line[31:0];
			case (op)
				4'h0: done = 1'b1;
				4'h1: wb_access(1'b1, adr[1:0], value, rdata);
				4'h2: begin
					wb_access(1'b0, adr[1:0], 32'd0, rdata);
					check_value("wb_dat_r", rdata & value, exp_val);
				end
				4'h3: begin
					for (i = 0; i < int'(value); i++) begin
						maddr         = adr[8:0] + 9'(i);
						model[maddr]  = 8'($urandom());
						host_buf.addr = maddr;
						host_buf.data = model[maddr];
						host_buf.wr   = 1'b1;
						next_cycle();
					end
					host_buf.wr = 1'b0;
				end
				4'h4: begin
					host_buf.addr = adr[8:0];
					next_cycle();
					check_value("buff_din", {24'd0, buff_din}, exp_val);
				end
				4'h5: begin
					for (i = 0; i < int'(value); i++) begin
						maddr = adr[8:0] + 9'(i);
						wb_access(1'b0, `DISK_REG_DATA, 32'd0, rdata);
						check_value("wb_dat_r", rdata, {24'd0, model[maddr]});
					end
				end
				4'h6: begin
					sd_ack = value[`DISK_SLOTS-1:0];
					next_cycle();
					sd_ack = '0;
					next_cycle();
				end
				4'h7: begin
					mount.mounted   = adr[2:0];
					mount.readonly  = adr[3];
					mount.file_type = adr[5:4];
					mount.size      = value;
					next_cycle();
					mount.mounted = '0;
					next_cycle();
				end
				4'h8: begin
					areset = 1'b1;
					repeat (4) next_cycle();
					areset = 1'b0;
				end
				4'h9: begin
					if (adr[0]) begin
						check_value("sd_req.lba", sd_req.lba, exp_val);
					end else begin
						check_value("sd_req.rd_wr", {26'd0, sd_req.rd, sd_req.wr}, exp_val);
					end
				end
				default: begin
					$display("unknown operation code %h in the tests file at entry %0d", op, n);
					errors++;
					done = 1'b1;
				end
			endcase
			if (timed_out || n == 6'(MAX_OPS - 1)) begin
				done = 1'b1;
			end
			n++;
		end

		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== disk_bridge_tests.txt ====
// op_adr_value_expected in hex. op 1 wb write, 2 wb read (value masks dat_r), 3 host random fill
// 4 host read, 5 DATA reads against fill, 6 sd_ack pulse, 7 mount, 8 reset, 9 sd_req check, 0 end
// mount adr holds file type [5:4], readonly [3] and mounted slots [2:0]
2_001_00000003_00000001  // status after reset
1_003_00000000_00000000  // pointer clear
1_002_000000a5_00000000
1_002_0000003c_00000000
1_002_ffffff81_00000000
4_000_00000000_000000a5
4_001_00000000_0000003c
4_002_00000000_00000081
3_000_00000008_00000000  // host fill 0..7
1_003_00000000_00000000
5_000_00000008_00000000
7_022_00012345_00000000  // slot 1, type 2
2_001_000000ff_00000047
1_000_00000001_00000000  // lba_sel on
1_002_0badcafe_00000000
9_001_00000000_0badcafe
2_002_ffffffff_00012345
1_000_0000000a_00000000  // block read on drive 1
9_000_00000000_00000010
2_001_00000001_00000000
6_000_00000001_00000000
9_000_00000000_00000000
2_001_00000001_00000001
1_000_00000024_00000000  // block write on drive 4
9_000_00000000_00000004
6_000_00000004_00000000
9_000_00000000_00000000
2_001_00000001_00000001
7_014_00000800_00000000  // slot 2, type 1
2_001_000000ff_000000b1
7_039_00000200_00000000  // slot 0, type 3, readonly
2_001_000000ff_000000e3
8_000_00000000_00000000
2_001_00000003_00000001
0_000_00000000_00000000

// ==== sources.f ====
+incdir+.
disk_bridge_pkg.sv
disk_regs.sv
disk_request.sv
sector_buffer.sv
mount_tracker.sv
disk_bridge_top.sv
disk_bridge_chk.sv
tb_disk_bridge.sv

// ==== Makefile ====
# Verilator build, run and lint for the disk bridge

TOP := tb_disk_bridge

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
	cat sim.log
	! grep -q "TESTS FAILED" sim.log

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
